// ==== logic/misc_pkg.sv ====
/* Misc peripheral shared definitions */
`default_nettype none

package misc_pkg;

	// Host bus widths
	localparam int data_w = 16;
	localparam int addr_w = 4;

	// Interrupt sources
	localparam int int_n = 5;

	// Refresh pacing
	localparam int ref_cnt_w = 4;
	localparam int ref_full = 8;
	localparam int base_div_w = 6;

	// Word register offsets, byte addressed
	typedef enum logic [addr_w-1:0] {
		reg_int  = 4'h0,
		reg_pit0 = 4'h4,
		reg_pit1 = 4'h8,
		reg_ref  = 4'hC
	} reg_addr_e;

	typedef enum logic {
		ref_idle,
		ref_request
	} ref_state_e;

	// APB request from the host
	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [addr_w-1:0] paddr;
		logic [data_w-1:0] pwdata;
	} apb_req_t;

	// Bit 0 is vid, bit 4 is dsp, matching the register layout
	typedef struct packed {
		logic dsp;
		logic tim;
		logic obj;
		logic gpu;
		logic vid;
	} int_src_t;

endpackage

`default_nettype wire

// ==== logic/apb_regs.sv ====
/* APB register block */
`timescale 1ns/1ps
`default_nettype none

module apb_regs import misc_pkg::*; (
	input  wire              sys_clk,
	input  wire              resetl,
	input  wire apb_req_t    apb_req,
	output logic [15:0]      prdata,
	output int_src_t         int_en,
	output int_src_t         int_ack,
	output logic             int_ack_wr,
	output logic [15:0]      pre_reload,
	output logic             pre_wr,
	output logic [15:0]      tim_reload,
	output logic             tim_wr,
	output logic [3:0]       ref_rate,
	input  wire int_src_t    pending,
	input  wire [15:0]       pre_count,
	input  wire [15:0]       tim_count,
	input  wire [3:0]        ref_count
);

	logic      acc;
	logic      wr;
	logic      rd;
	reg_addr_e addr;

	// Access phase of a transfer
	assign acc = apb_req.psel & apb_req.penable;
	assign wr = acc & apb_req.pwrite;
	assign rd = acc & ~apb_req.pwrite;
	assign addr = reg_addr_e'(apb_req.paddr);

	// One-cycle strobes at the access edge
	assign int_ack_wr = wr && (addr == reg_int);
	assign pre_wr = wr && (addr == reg_pit0);
	assign tim_wr = wr && (addr == reg_pit1);

	// Acknowledge bits live in the upper byte of the interrupt word
	assign int_ack = int_src_t'(apb_req.pwdata[8 +: int_n]);

	// Reload values go straight through with their strobes
	assign pre_reload = apb_req.pwdata;
	assign tim_reload = apb_req.pwdata;

	// Enable and rate are held here
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			int_en <= '0;
			ref_rate <= '0;
		end else begin
			if (int_ack_wr)
				int_en <= int_src_t'(apb_req.pwdata[int_n-1:0]);
			if (wr && (addr == reg_ref))
				ref_rate <= apb_req.pwdata[3:0];
		end
	end

	// Readback, zero outside a read
	always_comb begin
		prdata = '0;
		if (rd) begin
			case (addr)
				reg_int:  prdata = {{(data_w-int_n){1'b0}}, pending};
				reg_pit0: prdata = pre_count;
				reg_pit1: prdata = tim_count;
				reg_ref:  prdata = {{(data_w-ref_cnt_w){1'b0}}, ref_count};
				default:  prdata = '0;
			endcase
		end
	end

	// Access phase must follow a setup cycle with psel already high
	a_apb_phase: assert property (@(posedge sys_clk) disable iff (!resetl)
		apb_req.penable |-> apb_req.psel && $past(apb_req.psel && !apb_req.penable));

endmodule

`default_nettype wire

// ==== logic/int_ctrl.sv ====
/* Interrupt controller */
`timescale 1ns/1ps
`default_nettype none

module int_ctrl import misc_pkg::*; (
	input  wire           sys_clk,
	input  wire           resetl,
	input  wire int_src_t src,
	input  wire int_src_t int_en,
	input  wire int_src_t int_ack,
	input  wire           int_ack_wr,
	output int_src_t      pending,
	output logic          irq_n
);

	// Bit 0 carries vid and bit 1 carries dsp
	logic [1:0] sync1;
	logic [1:0] sync2;
	logic [1:0] sync_d;
	logic [1:0] edge_rise;
	int_src_t   set_vec;
	int_src_t   clr_vec;

	// Two-flop synchronizer plus a delay stage for edge detection
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			sync1 <= '0;
			sync2 <= '0;
			sync_d <= '0;
		end else begin
			sync1 <= {src.dsp, src.vid};
			sync2 <= sync1;
			sync_d <= sync2;
		end
	end

	// One pulse per rising edge so a held input does not retrigger
	assign edge_rise = sync2 & ~sync_d;

	// Edge sources for vid and dsp and level sources for the rest
	always_comb begin
		set_vec.vid = edge_rise[0] & int_en.vid;
		set_vec.gpu = src.gpu & int_en.gpu;
		set_vec.obj = src.obj & int_en.obj;
		set_vec.tim = src.tim & int_en.tim;
		set_vec.dsp = edge_rise[1] & int_en.dsp;
	end

	assign clr_vec = int_ack_wr ? int_ack : '0;

	// Set beats acknowledge in the same cycle
	always_ff @(posedge sys_clk) begin
		if (!resetl)
			pending <= '0;
		else
			pending <= set_vec | (pending & ~clr_vec);
	end

	// Active low while any flag is pending
	assign irq_n = ~(|pending);

	// A rising vid reaches pending three edges after it was sampled
	a_vid_latency: assert property (@(posedge sys_clk) disable iff (!resetl)
		$rose(pending.vid) |-> $past(src.vid, 3));

	// Same synchronizer depth on the dsp path
	a_dsp_latency: assert property (@(posedge sys_clk) disable iff (!resetl)
		$rose(pending.dsp) |-> $past(src.dsp, 3));

endmodule

`default_nettype wire

// ==== logic/interval_timer.sv ====
/* Interval timer */
`timescale 1ns/1ps
`default_nettype none

module interval_timer import misc_pkg::*; (
	input  wire         sys_clk,
	input  wire         resetl,
	input  wire  [15:0] pre_reload,
	input  wire         pre_wr,
	input  wire  [15:0] tim_reload,
	input  wire         tim_wr,
	output logic [15:0] pre_count,
	output logic [15:0] tim_count,
	output logic        tim_tick
);

	logic [data_w-1:0] pre_rl;
	logic [data_w-1:0] tim_rl;
	logic              pre_run;
	logic              pre_tick;

	// Zero prescaler reload stops everything
	assign pre_run = (pre_rl != '0);

	// Prescaler wraps at zero unless a write lands in the same cycle
	assign pre_tick = pre_run && (pre_count == '0) && !pre_wr;

	// Timer expiry on a prescaler tick
	assign tim_tick = pre_tick && (tim_count == '0) && !tim_wr;

	// Reload registers
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			pre_rl <= '0;
			tim_rl <= '0;
		end else begin
			if (pre_wr)
				pre_rl <= pre_reload;
			if (tim_wr)
				tim_rl <= tim_reload;
		end
	end

	// Prescaler down-counter that loads on write
	always_ff @(posedge sys_clk) begin
		if (!resetl)
			pre_count <= '0;
		else if (pre_wr)
			pre_count <= pre_reload;
		else if (pre_tick)
			pre_count <= pre_rl;
		else if (pre_run)
			pre_count <= pre_count - 16'd1;
	end

	// Timer down-counter stepping only on prescaler ticks
	always_ff @(posedge sys_clk) begin
		if (!resetl)
			tim_count <= '0;
		else if (tim_wr)
			tim_count <= tim_reload;
		else if (tim_tick)
			tim_count <= tim_rl;
		else if (pre_tick)
			tim_count <= tim_count - 16'd1;
	end

	// A stopped prescaler sits at zero
	a_no_tick_stopped: assert property (@(posedge sys_clk) disable iff (!resetl)
		(pre_rl == '0) |-> (pre_count == '0));

endmodule

`default_nettype wire

// ==== logic/refresh_ctrl.sv ====
/* DRAM refresh pacer */
`timescale 1ns/1ps
`default_nettype none

module refresh_ctrl import misc_pkg::*; (
	input  wire        sys_clk,
	input  wire        resetl,
	input  wire  [3:0] ref_rate,
	input  wire        start_ref,
	input  wire        ref_ack,
	output logic [3:0] ref_count,
	output logic       ref_req
);

	logic [base_div_w-1:0] base_div;
	logic                  base_tick;
	logic [3:0]            rate_cnt;
	logic                  rate_reload;
	logic                  inc;
	logic                  dec;
	logic                  full;
	logic                  not_empty;
	ref_state_e            state;
	ref_state_e            state_nxt;

	// Free-running base divider, one tick per wrap
	always_ff @(posedge sys_clk) begin
		if (!resetl)
			base_div <= '0;
		else
			base_div <= base_div + 1'b1;
	end

	assign base_tick = &base_div;

	// Rate counter reloads at zero on a base tick
	assign rate_reload = base_tick && (rate_cnt == '0);

	always_ff @(posedge sys_clk) begin
		if (!resetl)
			rate_cnt <= '0;
		else if (rate_reload)
			rate_cnt <= ref_rate;
		else if (base_tick)
			rate_cnt <= rate_cnt - 4'd1;
	end

	// Rate of zero disables pacing
	assign inc = rate_reload && (ref_rate != '0);
	// Refresh done handshake
	assign dec = ref_req && ref_ack;

	assign full = (ref_count == ref_cnt_w'(ref_full));
	assign not_empty = (ref_count != '0);

	// Pending count, saturates at full, inc with dec cancels
	always_ff @(posedge sys_clk) begin
		if (!resetl)
			ref_count <= '0;
		else if (inc && !dec && !full)
			ref_count <= ref_count + 4'd1;
		else if (dec && !inc)
			ref_count <= ref_count - 4'd1;
	end

	// Request FSM
	always_comb begin
		state_nxt = state;
		case (state)
			ref_idle:
				if (full || (start_ref && not_empty))
					state_nxt = ref_request;
			ref_request:
				if (!not_empty)
					state_nxt = ref_idle;
			default: state_nxt = ref_idle;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl)
			state <= ref_idle;
		else
			state <= state_nxt;
	end

	assign ref_req = (state == ref_request) && not_empty;

	a_count_bound: assert property (@(posedge sys_clk) disable iff (!resetl)
		ref_count <= ref_cnt_w'(ref_full));

	// Withheld ack keeps the request up
	a_req_hold: assert property (@(posedge sys_clk) disable iff (!resetl)
		ref_req && !ref_ack |=> ref_req);

endmodule

`default_nettype wire

// ==== logic/misc_top.sv ====
/* Misc peripheral top level */
`timescale 1ns/1ps
`default_nettype none

module misc_top import misc_pkg::*; (
	input  wire            sys_clk,
	input  wire            resetl,
	input  wire apb_req_t  apb_req,
	output logic [15:0]    prdata,
	input  wire int_src_t  int_src,
	input  wire            start_ref,
	input  wire            ref_ack,
	output logic           ref_req,
	output logic           irq_n
);

	int_src_t    int_en;
	int_src_t    int_ack;
	logic        int_ack_wr;
	int_src_t    pending;
	int_src_t    src_mux;
	logic [15:0] pre_reload;
	logic        pre_wr;
	logic [15:0] tim_reload;
	logic        tim_wr;
	logic [15:0] pre_count;
	logic [15:0] tim_count;
	logic        tim_tick;
	logic [3:0]  ref_rate;
	logic [3:0]  ref_count;

	// Timer source comes from inside, the external pin is not used
	always_comb begin
		src_mux = int_src;
		src_mux.tim = tim_tick;
	end

	apb_regs u_regs (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.apb_req    (apb_req),
		.prdata     (prdata),
		.int_en     (int_en),
		.int_ack    (int_ack),
		.int_ack_wr (int_ack_wr),
		.pre_reload (pre_reload),
		.pre_wr     (pre_wr),
		.tim_reload (tim_reload),
		.tim_wr     (tim_wr),
		.ref_rate   (ref_rate),
		.pending    (pending),
		.pre_count  (pre_count),
		.tim_count  (tim_count),
		.ref_count  (ref_count)
	);

	int_ctrl u_int (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.src        (src_mux),
		.int_en     (int_en),
		.int_ack    (int_ack),
		.int_ack_wr (int_ack_wr),
		.pending    (pending),
		.irq_n      (irq_n)
	);

	interval_timer u_pit (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.pre_reload (pre_reload),
		.pre_wr     (pre_wr),
		.tim_reload (tim_reload),
		.tim_wr     (tim_wr),
		.pre_count  (pre_count),
		.tim_count  (tim_count),
		.tim_tick   (tim_tick)
	);

	refresh_ctrl u_ref (
		.sys_clk   (sys_clk),
		.resetl    (resetl),
		.ref_rate  (ref_rate),
		.start_ref (start_ref),
		.ref_ack   (ref_ack),
		.ref_count (ref_count),
		.ref_req   (ref_req)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
/* Testbench clock and reset */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic sys_clk,
	output logic resetl
);

	// 4 ns period
	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// Reset held for three cycles, released on a falling edge
	initial begin
		resetl = 1'b0;
		repeat (3) @(posedge sys_clk);
		@(negedge sys_clk);
		resetl = 1'b1;
	end

endmodule

`default_nettype wire

// ==== testbench/misc_tb.sv ====
/* Misc peripheral testbench */
`timescale 1ns/1ps
`default_nettype none

module misc_tb import misc_pkg::*; ();

	localparam int max_cycles = 6000;

	// Pending and enable masks in reg_int
	localparam logic [15:0] m_vid = 16'h0001;
	localparam logic [15:0] m_gpu = 16'h0002;
	localparam logic [15:0] m_obj = 16'h0004;
	localparam logic [15:0] m_tim = 16'h0008;
	localparam logic [15:0] ack_all = 16'h1f00;

	logic        sys_clk;
	logic        resetl;
	apb_req_t    apb_req;
	logic [15:0] prdata;
	int_src_t    int_src;
	logic        start_ref;
	logic        ref_ack;
	logic        ref_req;
	logic        irq_n;

	int     cycles = 0;
	int     write_cyc = 0;
	int     read_cyc = 0;
	int     test_errs = 0;
	int     total_errs = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	string  cur_test;
	integer seed = 32'he40b;

	tb_clock clk0 (
		.sys_clk (sys_clk),
		.resetl  (resetl)
	);

	misc_top dut0 (
		.sys_clk   (sys_clk),
		.resetl    (resetl),
		.apb_req   (apb_req),
		.prdata    (prdata),
		.int_src   (int_src),
		.start_ref (start_ref),
		.ref_ack   (ref_ack),
		.ref_req   (ref_req),
		.irq_n     (irq_n)
	);

	// Run limit
	always @(posedge sys_clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Setup then access, write edge is the rising edge after access starts
	task automatic apb_write(input reg_addr_e addr, input logic [15:0] data);
		@(negedge sys_clk);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b1;
		apb_req.paddr = addr;
		apb_req.pwdata = data;
		@(negedge sys_clk);
		apb_req.penable = 1'b1;
		@(negedge sys_clk);
		write_cyc = cycles;
		apb_req = '0;
	endtask

	// prdata sampled inside the access phase
	task automatic apb_read(input reg_addr_e addr, output logic [15:0] data);
		@(negedge sys_clk);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b0;
		apb_req.paddr = addr;
		apb_req.pwdata = '0;
		@(negedge sys_clk);
		apb_req.penable = 1'b1;
		#1;
		data = prdata;
		read_cyc = cycles;
		@(negedge sys_clk);
		apb_req = '0;
	endtask

	task automatic check_word(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp) else begin
			$display("error at %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, got);
			test_errs++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("error at %0t ns: %s expected %b, got %b", $time, name, exp, got);
			test_errs++;
		end
	endtask

	task automatic check_cond(input logic ok, input string what);
		assert (ok) else begin
			$display("failure at %0t ns: %s", $time, what);
			test_errs++;
		end
	endtask

	task automatic read_check(input reg_addr_e addr, input string name,
		input logic [15:0] exp);
		logic [15:0] got;
		apb_read(addr, got);
		check_word(name, got, exp);
	endtask

	// Polls on falling edges, n is -1 if the level never showed
	task automatic wait_irq(input logic level, input int limit, output int n);
		n = -1;
		for (int i = 1; i <= limit; i++) begin
			@(negedge sys_clk);
			if (irq_n == level) begin
				n = i;
				break;
			end
		end
	endtask

	task automatic wait_req(input logic level, input int limit, output int n);
		n = -1;
		for (int i = 1; i <= limit; i++) begin
			@(negedge sys_clk);
			if (ref_req == level) begin
				n = i;
				break;
			end
		end
	endtask

	// Reads the refresh count over APB until it matches
	task automatic wait_count(input logic [15:0] exp, input int limit, output logic seen);
		logic [15:0] got;
		int start;
		start = cycles;
		seen = 1'b0;
		while (!seen && (cycles - start) <= limit) begin
			apb_read(reg_ref, got);
			if (got == exp)
				seen = 1'b1;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		tests_run++;
		total_errs += test_errs;
		if (test_errs == 0) begin
			$display("test %s: passed", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", cur_test, test_errs);
		end
	endtask

	task automatic test_reset_readback();
		logic [15:0] t_val;
		logic [15:0] p_val;
		logic [15:0] got;
		start_test("reset_readback");
		check_bit("irq_n", irq_n, 1'b1);
		check_bit("ref_req", ref_req, 1'b0);
		check_word("prdata", prdata, 16'h0000);
		read_check(reg_int, "pending", 16'h0000);
		read_check(reg_pit0, "prescaler count", 16'h0000);
		read_check(reg_pit1, "timer count", 16'h0000);
		read_check(reg_ref, "refresh count", 16'h0000);
		// Timer holds its loaded value while the prescaler is stopped
		t_val = 16'($random(seed));
		apb_write(reg_pit1, t_val);
		read_check(reg_pit1, "timer count", t_val);
		// Large prescaler value counts down one per cycle from the write
		p_val = 16'($random(seed)) | 16'h0100;
		apb_write(reg_pit0, p_val);
		apb_read(reg_pit0, got);
		check_word("prescaler count", got, p_val - 16'(read_cyc - write_cyc));
		apb_write(reg_pit0, 16'h0000);
		read_check(reg_pit0, "prescaler count", 16'h0000);
		read_check(reg_pit1, "timer count", t_val);
		end_test();
	endtask

	task automatic test_level_irq();
		int n;
		start_test("level_irq");
		apb_write(reg_int, m_gpu | m_obj | ack_all);
		@(negedge sys_clk);
		int_src.gpu = 1'b1;
		wait_irq(1'b0, 3, n);
		check_cond(n > 0, "irq_n did not fall after enabled gpu went high");
		read_check(reg_int, "pending", m_gpu);
		// Disabled dsp pulse must leave pending alone
		@(negedge sys_clk);
		int_src.gpu = 1'b0;
		int_src.dsp = 1'b1;
		repeat (3) @(negedge sys_clk);
		int_src.dsp = 1'b0;
		repeat (4) @(negedge sys_clk);
		read_check(reg_int, "pending", m_gpu);
		apb_write(reg_int, m_gpu | m_obj | (m_gpu << 8));
		check_bit("irq_n", irq_n, 1'b1);
		read_check(reg_int, "pending", 16'h0000);
		end_test();
	endtask

	task automatic test_edge_irq();
		int n;
		logic again;
		start_test("edge_irq");
		apb_write(reg_int, m_vid | ack_all);
		@(negedge sys_clk);
		int_src.vid = 1'b1;
		wait_irq(1'b0, 6, n);
		check_cond(n > 0, "rising vid edge did not set its pending bit");
		apb_write(reg_int, m_vid | (m_vid << 8));
		// vid still high, no new edge
		again = 1'b0;
		repeat (12) begin
			@(negedge sys_clk);
			if (irq_n !== 1'b1)
				again = 1'b1;
		end
		check_cond(!again, "vid held high set pending a second time");
		read_check(reg_int, "pending", 16'h0000);
		@(negedge sys_clk);
		int_src.vid = 1'b0;
		repeat (4) @(negedge sys_clk);
		int_src.vid = 1'b1;
		wait_irq(1'b0, 6, n);
		check_cond(n > 0, "second vid edge did not set its pending bit");
		read_check(reg_int, "pending", m_vid);
		@(negedge sys_clk);
		int_src.vid = 1'b0;
		apb_write(reg_int, ack_all);
		check_bit("irq_n", irq_n, 1'b1);
		end_test();
	endtask

	task automatic test_timer_irq();
		int n;
		start_test("timer_irq");
		apb_write(reg_int, m_tim | ack_all);
		apb_write(reg_pit1, 16'd4);
		apb_write(reg_pit0, 16'd3);
		// Period is (3+1)*(4+1) = 20 cycles
		wait_irq(1'b0, 22, n);
		check_cond(n > 0, "first timer interrupt did not arrive");
		apb_write(reg_int, m_tim | (m_tim << 8));
		wait_irq(1'b0, 20, n);
		check_cond(n > 0, "timer interrupt did not come back within 20 cycles");
		if (n > 0)
			check_cond(n > 15, "timer interrupt came back within 15 cycles");
		read_check(reg_int, "pending", m_tim);
		apb_write(reg_pit0, 16'h0000);
		apb_write(reg_int, ack_all);
		check_bit("irq_n", irq_n, 1'b1);
		end_test();
	endtask

	task automatic test_refresh();
		int n;
		logic seen;
		logic dropped;
		start_test("refresh");
		apb_write(reg_ref, 16'd1);
		wait_count(16'd1, 140, seen);
		check_cond(seen, "refresh count did not reach 1 within 140 cycles");
		check_bit("ref_req", ref_req, 1'b0);
		wait_req(1'b1, 1200, n);
		check_cond(n > 0, "ref_req did not rise with the count filling up");
		read_check(reg_ref, "refresh count", 16'd8);
		// Ack withheld, request holds and the count saturates
		dropped = 1'b0;
		repeat (130) begin
			@(negedge sys_clk);
			if (ref_req !== 1'b1)
				dropped = 1'b1;
		end
		check_cond(!dropped, "ref_req fell while ref_ack was withheld");
		read_check(reg_ref, "refresh count", 16'd8);
		// Eight handshakes empty the count
		@(negedge sys_clk);
		ref_ack = 1'b1;
		wait_req(1'b0, 20, n);
		ref_ack = 1'b0;
		check_cond(n > 0, "ref_req did not fall while draining");
		if (n > 0)
			check_cond(n >= 8, "count drained in fewer than eight handshakes");
		// Count of 1 plus start_ref
		wait_count(16'd1, 140, seen);
		check_cond(seen, "refresh count did not return to 1");
		check_bit("ref_req", ref_req, 1'b0);
		@(negedge sys_clk);
		start_ref = 1'b1;
		@(negedge sys_clk);
		start_ref = 1'b0;
		wait_req(1'b1, 3, n);
		check_cond(n > 0, "start_ref with a nonzero count did not raise ref_req");
		ref_ack = 1'b1;
		wait_req(1'b0, 4, n);
		ref_ack = 1'b0;
		check_cond(n > 0, "ref_req did not fall after the single refresh");
		apb_write(reg_ref, 16'd0);
		end_test();
	endtask

	initial begin
		apb_req = '0;
		int_src = '0;
		start_ref = 1'b0;
		ref_ack = 1'b0;
		wait (resetl === 1'b1);
		@(negedge sys_clk);
		test_reset_readback();
		test_level_irq();
		test_edge_irq();
		test_timer_irq();
		test_refresh();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
		if (total_errs == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
logic/misc_pkg.sv
logic/apb_regs.sv
logic/int_ctrl.sv
logic/interval_timer.sv
logic/refresh_ctrl.sv
logic/misc_top.sv
testbench/tb_clock.sv
testbench/misc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile misc_tb with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module misc_tb -f build.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vmisc_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi
exit 1
